// ==== Makefile ====
TOP := tb_invaders_video_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f invaders_video_core.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== invaders_video_core.f ====
src/invaders_pkg.sv
src/bridge_regs.sv
src/reset_sequencer.sv
src/video_timing.sv
src/display_ram.sv
src/scanline_fetch.sv
src/color_overlay.sv
src/invaders_video_core.sv
verif/tb_invaders_video_core.sv

// ==== src/bridge_regs.sv ====
/*
 * host bridge decode
 * settings register with change pulse, read mux,
 * registered display RAM write port
 */
`timescale 1ns/1ps

module bridge_regs (
    input  logic                       clk_74a,
    input  logic                       reset_n,
    input  invaders_pkg::bridge_word_t bridge_addr,
    input  logic                       bridge_wr,
    input  logic                       bridge_rd,
    input  invaders_pkg::bridge_word_t bridge_wr_data,
    output invaders_pkg::bridge_word_t bridge_rd_data,
    output invaders_pkg::bridge_word_t settings,
    output logic                       settings_changed,
    output logic                       vram_wr,
    output invaders_pkg::vram_addr_t   vram_wr_addr,
    output invaders_pkg::vram_data_t   vram_wr_data
);

    logic settings_sel;
    logic vram_sel;

    // settings occupy 0x2000_0000 to 0x2000_000f
    assign settings_sel = (bridge_addr[31:28] == invaders_pkg::SETTINGS_ADDR_HI) &&
                          (bridge_addr[27:4] == '0);
    assign vram_sel     = (bridge_addr[31:28] == invaders_pkg::VRAM_WINDOW_HI);

    // read data valid while the read strobe is up
    assign bridge_rd_data = (bridge_rd && settings_sel) ? settings : '0;

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            settings         <= '0;
            settings_changed <= 1'b0;
            vram_wr          <= 1'b0;
        end else begin
            settings_changed <= 1'b0;
            vram_wr          <= bridge_wr && vram_sel;
            if (bridge_wr && settings_sel) begin
                settings         <= bridge_wr_data;
                settings_changed <= 1'b1;
            end
        end
    end

    // byte address and low data byte for the display RAM
    always_ff @(posedge clk_74a) begin
        vram_wr_addr <= bridge_addr[12:0];
        vram_wr_data <= bridge_wr_data[7:0];
    end

endmodule

// ==== src/color_overlay.sv ====
/*
 * colour overlay and output stage
 * band colour lookup from the visible coordinates,
 * registered rgb, de, hs and vs
 */
`timescale 1ns/1ps

module color_overlay (
    input  logic                 clk_74a,
    input  logic                 reset_n,
    input  logic                 pixel_on,
    input  invaders_pkg::coord_t visible_x,
    input  invaders_pkg::coord_t visible_y,
    input  logic                 fetch_hs,
    input  logic                 fetch_vs,
    input  logic                 fetch_de,
    output invaders_pkg::rgb_t   video_rgb,
    output logic                 video_de,
    output logic                 video_hs,
    output logic                 video_vs
);

    invaders_pkg::rgb_t band_color;

    // vertical stripes, split by y at both edges of the screen
    always_comb begin
        if (visible_x > invaders_pkg::BAND_X_R1) begin
            if (visible_y < invaders_pkg::BAND_Y_TOP) band_color = invaders_pkg::COLOR_CYAN;
            else if (visible_y < invaders_pkg::BAND_Y_MID) band_color = invaders_pkg::COLOR_RED;
            else band_color = invaders_pkg::COLOR_YELLOW;
        end else if (visible_x > invaders_pkg::BAND_X_R2) begin
            if (visible_y < invaders_pkg::BAND_Y_TOP) band_color = invaders_pkg::COLOR_WHITE;
            else if (visible_y < invaders_pkg::BAND_Y_MID) band_color = invaders_pkg::COLOR_GREEN;
            else band_color = invaders_pkg::COLOR_YELLOW;
        end else if (visible_x > invaders_pkg::BAND_X_R3) band_color = invaders_pkg::COLOR_RED;
        else if (visible_x > invaders_pkg::BAND_X_R4) band_color = invaders_pkg::COLOR_GREEN;
        else if (visible_x > invaders_pkg::BAND_X_R5) band_color = invaders_pkg::COLOR_CYAN;
        else if (visible_x > invaders_pkg::BAND_X_R6) band_color = invaders_pkg::COLOR_MAGENTA;
        else if (visible_x > invaders_pkg::BAND_X_R7) band_color = invaders_pkg::COLOR_CYAN;
        else if (visible_x > invaders_pkg::BAND_X_R8) band_color = invaders_pkg::COLOR_RED;
        else if (visible_x > invaders_pkg::BAND_X_R9) band_color = invaders_pkg::COLOR_CYAN;
        else if (visible_x > invaders_pkg::BAND_X_R10) band_color = invaders_pkg::COLOR_RED;
        else if (visible_y > invaders_pkg::BAND_Y_LEFT_LO &&
                 visible_y < invaders_pkg::BAND_Y_LEFT_HI) begin
            band_color = invaders_pkg::COLOR_MAGENTA;
        end else begin
            band_color = invaders_pkg::COLOR_CYAN;
        end
    end

    // unlit and blanked pixels are black
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= invaders_pkg::COLOR_BLACK;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            video_rgb <= (fetch_de && pixel_on) ? band_color : invaders_pkg::COLOR_BLACK;
            video_de  <= fetch_de;
            video_hs  <= fetch_hs;
            video_vs  <= fetch_vs;
        end
    end

endmodule

// ==== src/display_ram.sv ====
/*
 * display RAM, 8K bytes
 * host write port and registered video read port
 */
`timescale 1ns/1ps

module display_ram (
    input  logic                     clk_74a,
    input  logic                     vram_wr,
    input  invaders_pkg::vram_addr_t vram_wr_addr,
    input  invaders_pkg::vram_data_t vram_wr_data,
    input  invaders_pkg::vram_addr_t vram_rd_addr,
    output invaders_pkg::vram_data_t vram_rd_data
);

    invaders_pkg::vram_data_t mem [0:8191];

    // blank screen at power up
    initial begin
        for (int i = 0; i < 8192; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_74a) begin
        if (vram_wr) begin
            mem[vram_wr_addr] <= vram_wr_data;
        end
    end

    // one clock read latency
    always_ff @(posedge clk_74a) begin
        vram_rd_data <= mem[vram_rd_addr];
    end

endmodule

// ==== src/invaders_pkg.sv ====
/*
 * shared package for the video core
 * bus and pixel types, bridge window nibbles, raster timing defaults,
 * colour overlay band edges and palette
 */
package invaders_pkg;

    typedef logic [31:0] bridge_word_t;
    typedef logic [12:0] vram_addr_t;
    typedef logic [7:0]  vram_data_t;
    typedef logic [9:0]  coord_t;
    typedef logic [23:0] rgb_t;

    // raster timing, one pixel per clock
    localparam int H_TOTAL_DEFAULT = 320;
    localparam int V_TOTAL_DEFAULT = 262;
    localparam int H_BPORCH        = 31;
    localparam int V_BPORCH        = 16;
    localparam int H_ACTIVE        = 256;
    localparam int V_ACTIVE        = 224;
    // line sync a few clocks after frame sync
    localparam int HS_OFFSET       = 3;

    // displayed region of the display RAM
    localparam int LINE_BYTES      = 32;
    localparam int VRAM_LINE_BASE  = 'h400;

    // bridge windows by top address nibble
    localparam logic [3:0] SETTINGS_ADDR_HI = 4'h2;
    localparam logic [3:0] VRAM_WINDOW_HI   = 4'h1;

    // overlay band edges, strict greater-than on visible x
    localparam int BAND_X_R1 = 236;
    localparam int BAND_X_R2 = 222;
    localparam int BAND_X_R3 = 204;
    localparam int BAND_X_R4 = 159;
    localparam int BAND_X_R5 = 127;
    localparam int BAND_X_R6 = 111;
    localparam int BAND_X_R7 = 63;
    localparam int BAND_X_R8 = 43;
    localparam int BAND_X_R9 = 24;
    localparam int BAND_X_R10 = 15;
    // y splits, right bands and leftmost band
    localparam int BAND_Y_TOP     = 80;
    localparam int BAND_Y_MID     = 150;
    localparam int BAND_Y_LEFT_LO = 120;
    localparam int BAND_Y_LEFT_HI = 190;

    localparam rgb_t COLOR_CYAN    = 24'h42E9F4;
    localparam rgb_t COLOR_RED     = 24'hF83B3A;
    localparam rgb_t COLOR_YELLOW  = 24'hEBDF64;
    localparam rgb_t COLOR_WHITE   = 24'hFFFFFF;
    localparam rgb_t COLOR_GREEN   = 24'h62DE6D;
    localparam rgb_t COLOR_MAGENTA = 24'hDB55DD;
    localparam rgb_t COLOR_BLACK   = 24'h000000;

endpackage

// ==== src/invaders_video_core.sv ====
/*
 * video core top level
 * bridge registers, reset sequencer and the raster pipeline
 * timing, fetch, display RAM, colour overlay
 */
`timescale 1ns/1ps

module invaders_video_core #(
    parameter int H_TOTAL = invaders_pkg::H_TOTAL_DEFAULT,
    parameter int V_TOTAL = invaders_pkg::V_TOTAL_DEFAULT
) (
    input  logic                       clk_74a,
    input  logic                       reset_n,
    input  invaders_pkg::bridge_word_t bridge_addr,
    input  logic                       bridge_wr,
    input  logic                       bridge_rd,
    input  invaders_pkg::bridge_word_t bridge_wr_data,
    input  logic                       menu_visible,
    output invaders_pkg::bridge_word_t bridge_rd_data,
    output logic                       cpu_reset_n,
    output invaders_pkg::bridge_word_t settings,
    output invaders_pkg::rgb_t         video_rgb,
    output logic                       video_de,
    output logic                       video_hs,
    output logic                       video_vs
);

    logic                     settings_changed;
    logic                     vram_wr;
    invaders_pkg::vram_addr_t vram_wr_addr;
    invaders_pkg::vram_data_t vram_wr_data;
    invaders_pkg::vram_addr_t vram_rd_addr;
    invaders_pkg::vram_data_t vram_rd_data;
    invaders_pkg::coord_t     x_count;
    invaders_pkg::coord_t     y_count;
    logic                     line_start;
    logic                     frame_start;
    logic                     active;
    logic                     pixel_on;
    invaders_pkg::coord_t     visible_x;
    invaders_pkg::coord_t     visible_y;
    logic                     fetch_hs;
    logic                     fetch_vs;
    logic                     fetch_de;

    ////////////////////////////////////////////////////////////////////////////
    // host side

    bridge_regs bridge_regs_inst (
        .clk_74a(clk_74a), .reset_n(reset_n),
        .bridge_addr(bridge_addr), .bridge_wr(bridge_wr), .bridge_rd(bridge_rd),
        .bridge_wr_data(bridge_wr_data), .bridge_rd_data(bridge_rd_data),
        .settings(settings), .settings_changed(settings_changed),
        .vram_wr(vram_wr), .vram_wr_addr(vram_wr_addr), .vram_wr_data(vram_wr_data)
    );

    reset_sequencer reset_sequencer_inst (
        .clk_74a(clk_74a), .reset_n(reset_n),
        .settings_changed(settings_changed), .menu_visible(menu_visible),
        .cpu_reset_n(cpu_reset_n)
    );

    ////////////////////////////////////////////////////////////////////////////
    // video pipeline, two clocks from counters to outputs

    video_timing #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) video_timing_inst (
        .clk_74a(clk_74a), .reset_n(reset_n),
        .x_count(x_count), .y_count(y_count), .line_start(line_start),
        .frame_start(frame_start), .active(active)
    );

    scanline_fetch scanline_fetch_inst (
        .clk_74a(clk_74a), .reset_n(reset_n),
        .x_count(x_count), .y_count(y_count), .line_start(line_start),
        .frame_start(frame_start), .active(active), .vram_rd_data(vram_rd_data),
        .vram_rd_addr(vram_rd_addr), .pixel_on(pixel_on),
        .visible_x(visible_x), .visible_y(visible_y),
        .fetch_hs(fetch_hs), .fetch_vs(fetch_vs), .fetch_de(fetch_de)
    );

    display_ram display_ram_inst (
        .clk_74a(clk_74a),
        .vram_wr(vram_wr), .vram_wr_addr(vram_wr_addr), .vram_wr_data(vram_wr_data),
        .vram_rd_addr(vram_rd_addr), .vram_rd_data(vram_rd_data)
    );

    color_overlay color_overlay_inst (
        .clk_74a(clk_74a), .reset_n(reset_n),
        .pixel_on(pixel_on), .visible_x(visible_x), .visible_y(visible_y),
        .fetch_hs(fetch_hs), .fetch_vs(fetch_vs), .fetch_de(fetch_de),
        .video_rgb(video_rgb), .video_de(video_de),
        .video_hs(video_hs), .video_vs(video_vs)
    );

endmodule

// ==== src/reset_sequencer.sv ====
/*
 * core reset sequencer
 * holds a reset request from a settings write until the host menu closes,
 * then pulls cpu_reset_n low for two clocks
 */
`timescale 1ns/1ps

module reset_sequencer (
    input  logic clk_74a,
    input  logic reset_n,
    input  logic settings_changed,
    input  logic menu_visible,
    output logic cpu_reset_n
);

    logic need_reset;
    logic reset_ack;
    logic menu_visible_p;

    // pending request, dropped once the pulse has been issued
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            need_reset <= 1'b0;
        end else begin
            if (settings_changed) begin
                need_reset <= 1'b1;
            end else if (reset_ack) begin
                need_reset <= 1'b0;
            end
        end
    end

    // menu level only tracked while a request is pending
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            cpu_reset_n    <= 1'b0;
            reset_ack      <= 1'b0;
            menu_visible_p <= 1'b0;
        end else begin
            if (need_reset) begin
                menu_visible_p <= menu_visible;
                // menu just closed
                if (menu_visible_p && !menu_visible) begin
                    cpu_reset_n <= 1'b0;
                    reset_ack   <= 1'b1;
                end
            end else begin
                cpu_reset_n <= 1'b1;
                reset_ack   <= 1'b0;
            end
        end
    end

endmodule

// ==== src/scanline_fetch.sv ====
/*
 * scanline fetch
 * visible coordinates, display RAM byte address,
 * one-stage delay to meet read data, pixel bit select
 */
`timescale 1ns/1ps

module scanline_fetch (
    input  logic                     clk_74a,
    input  logic                     reset_n,
    input  invaders_pkg::coord_t     x_count,
    input  invaders_pkg::coord_t     y_count,
    input  logic                     line_start,
    input  logic                     frame_start,
    input  logic                     active,
    input  invaders_pkg::vram_data_t vram_rd_data,
    output invaders_pkg::vram_addr_t vram_rd_addr,
    output logic                     pixel_on,
    output invaders_pkg::coord_t     visible_x,
    output invaders_pkg::coord_t     visible_y,
    output logic                     fetch_hs,
    output logic                     fetch_vs,
    output logic                     fetch_de
);

    invaders_pkg::coord_t     vis_x;
    invaders_pkg::coord_t     vis_y;
    invaders_pkg::vram_addr_t line_base;
    invaders_pkg::vram_addr_t byte_col;

    assign vis_x = x_count - invaders_pkg::coord_t'(invaders_pkg::H_BPORCH);
    assign vis_y = y_count - invaders_pkg::coord_t'(invaders_pkg::V_BPORCH);

    // 32 bytes per line from the display base, wraps at 13 bits
    assign line_base = invaders_pkg::vram_addr_t'(invaders_pkg::VRAM_LINE_BASE) +
                       invaders_pkg::vram_addr_t'(vis_y[7:0]) *
                       invaders_pkg::vram_addr_t'(invaders_pkg::LINE_BYTES);
    // eight pixels per byte
    assign byte_col     = invaders_pkg::vram_addr_t'(vis_x[9:3]);
    assign vram_rd_addr = line_base + byte_col;

    ////////////////////////////////////////////////////////////////////////////
    // align with RAM read data

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            fetch_hs <= 1'b0;
            fetch_vs <= 1'b0;
            fetch_de <= 1'b0;
        end else begin
            fetch_hs <= line_start;
            fetch_vs <= frame_start;
            fetch_de <= active;
        end
    end

    always_ff @(posedge clk_74a) begin
        visible_x <= vis_x;
        visible_y <= vis_y;
    end

    // bit 0 is the leftmost pixel of the byte
    assign pixel_on = vram_rd_data[visible_x[2:0]];

endmodule

// ==== src/video_timing.sv ====
/*
 * raster timing generator
 * free-running pixel and line counters,
 * frame and line start strobes, active window flag
 */
`timescale 1ns/1ps

module video_timing #(
    parameter int H_TOTAL = invaders_pkg::H_TOTAL_DEFAULT,
    parameter int V_TOTAL = invaders_pkg::V_TOTAL_DEFAULT
) (
    input  logic                 clk_74a,
    input  logic                 reset_n,
    output invaders_pkg::coord_t x_count,
    output invaders_pkg::coord_t y_count,
    output logic                 line_start,
    output logic                 frame_start,
    output logic                 active
);

    localparam int H_START = invaders_pkg::H_BPORCH;
    localparam int H_END   = invaders_pkg::H_BPORCH + invaders_pkg::H_ACTIVE;
    localparam int V_START = invaders_pkg::V_BPORCH;
    localparam int V_END   = invaders_pkg::V_BPORCH + invaders_pkg::V_ACTIVE;

    logic h_last;
    logic v_last;
    logic h_active;
    logic v_active;

    assign h_last = (x_count == invaders_pkg::coord_t'(H_TOTAL - 1));
    assign v_last = (y_count == invaders_pkg::coord_t'(V_TOTAL - 1));

    ////////////////////////////////////////////////////////////////////////////
    // counters

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else begin
            if (h_last) begin
                x_count <= '0;
                if (v_last) begin
                    y_count <= '0;
                end else begin
                    y_count <= y_count + 1'b1;
                end
            end else begin
                x_count <= x_count + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // strobes and window

    // vs at the frame origin, hs a little later on every line
    assign frame_start = (x_count == '0) && (y_count == '0);
    assign line_start  = (x_count == invaders_pkg::coord_t'(invaders_pkg::HS_OFFSET));

    assign h_active = (x_count >= H_START) && (x_count < H_END);
    assign v_active = (y_count >= V_START) && (y_count < V_END);
    assign active   = h_active && v_active;

endmodule

// ==== verif/tb_invaders_video_core.sv ====
/*
 * testbench for the video core
 * clock and reset, bridge and menu stimulus, raster position model,
 * concurrent assertions on video, settings readback and core reset
 */
`timescale 1ns/1ps

module tb_invaders_video_core;

    localparam int unsigned RANDOM_SEED = 32'h5f4ceb78;
    localparam int FRAME_CYCLES = 320 * 262;

    logic                       clk_74a;
    logic                       reset_n;
    invaders_pkg::bridge_word_t bridge_addr;
    logic                       bridge_wr;
    logic                       bridge_rd;
    invaders_pkg::bridge_word_t bridge_wr_data;
    logic                       menu_visible;
    invaders_pkg::bridge_word_t bridge_rd_data;
    logic                       cpu_reset_n;
    invaders_pkg::bridge_word_t settings;
    invaders_pkg::rgb_t         video_rgb;
    logic                       video_de;
    logic                       video_hs;
    logic                       video_vs;

    // expected contents and raster position
    logic [7:0]                 shadow_vram [0:8191];
    invaders_pkg::bridge_word_t shadow_settings;
    logic                       reset_armed;
    logic                       run_live;
    logic                       vs_seen;
    logic [16:0]                cyc_since_vs;
    logic [8:0]                 de_in_line;
    logic [8:0]                 lines_in_frame;
    int                         low_run;
    int                         edge_count = 0;
    int                         mismatch_count = 0;
    int                         fail_count = 0;

    invaders_video_core invaders_video_core_inst (
        .clk_74a(clk_74a), .reset_n(reset_n),
        .bridge_addr(bridge_addr), .bridge_wr(bridge_wr), .bridge_rd(bridge_rd),
        .bridge_wr_data(bridge_wr_data), .menu_visible(menu_visible),
        .bridge_rd_data(bridge_rd_data), .cpu_reset_n(cpu_reset_n), .settings(settings),
        .video_rgb(video_rgb), .video_de(video_de),
        .video_hs(video_hs), .video_vs(video_vs)
    );

    always #5 clk_74a = ~clk_74a;

    ////////////////////////////////////////////////////////////////////////////
    // reference rules

    function automatic invaders_pkg::rgb_t band_color(input int x, input int y);
        if (x > 236) begin
            return (y < 80) ? invaders_pkg::COLOR_CYAN :
                   (y < 150) ? invaders_pkg::COLOR_RED : invaders_pkg::COLOR_YELLOW;
        end
        if (x > 222) begin
            return (y < 80) ? invaders_pkg::COLOR_WHITE :
                   (y < 150) ? invaders_pkg::COLOR_GREEN : invaders_pkg::COLOR_YELLOW;
        end
        if (x > 204) return invaders_pkg::COLOR_RED;
        if (x > 159) return invaders_pkg::COLOR_GREEN;
        if (x > 127) return invaders_pkg::COLOR_CYAN;
        if (x > 111) return invaders_pkg::COLOR_MAGENTA;
        if (x > 63) return invaders_pkg::COLOR_CYAN;
        if (x > 43) return invaders_pkg::COLOR_RED;
        if (x > 24) return invaders_pkg::COLOR_CYAN;
        if (x > 15) return invaders_pkg::COLOR_RED;
        if (y > 120 && y < 190) return invaders_pkg::COLOR_MAGENTA;
        return invaders_pkg::COLOR_CYAN;
    endfunction

    function automatic invaders_pkg::rgb_t expected_pixel(input int x, input int y);
        int offset;
        offset = (invaders_pkg::VRAM_LINE_BASE + (y % 256) * invaders_pkg::LINE_BYTES +
                  x / 8) % 8192;
        if (shadow_vram[offset][x % 8]) return band_color(x, y);
        return invaders_pkg::COLOR_BLACK;
    endfunction

    function automatic invaders_pkg::bridge_word_t expected_read(
        input invaders_pkg::bridge_word_t addr);
        if (addr[31:4] == 28'h200_0000) return shadow_settings;
        return '0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // raster position and core reset pulse model

    always @(posedge clk_74a) edge_count <= edge_count + 1;

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            run_live       <= 1'b0;
            vs_seen        <= 1'b0;
            cyc_since_vs   <= '0;
            de_in_line     <= '0;
            lines_in_frame <= '0;
            low_run        <= 0;
        end else begin
            run_live <= 1'b1;
            if (video_vs) begin
                vs_seen        <= 1'b1;
                cyc_since_vs   <= 17'd1;
                lines_in_frame <= '0;
            end else begin
                cyc_since_vs <= cyc_since_vs + 1'b1;
            end
            // a line counts as active once it held a full de run
            if (video_hs) begin
                de_in_line <= '0;
                if (de_in_line == 9'd256) lines_in_frame <= lines_in_frame + 1'b1;
            end else if (video_de) begin
                de_in_line <= de_in_line + 1'b1;
            end
            low_run <= (run_live && !cpu_reset_n) ? low_run + 1 : 0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks

    reset_state_check: assert property (@(posedge clk_74a)
        (edge_count > 1 && !reset_n) |->
        (video_rgb == '0 && !video_de && !video_hs && !video_vs && !cpu_reset_n))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: outputs in reset expected 0, got rgb %h de %b hs %b",
                 $time, $sampled(video_rgb), $sampled(video_de), $sampled(video_hs));
    end

    release_check: assert property (@(posedge clk_74a)
        (reset_n && $past(reset_n) && !$past(reset_n, 2)) |-> cpu_reset_n)
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: cpu_reset_n expected 1 got 0", $time);
    end

    frame_period_check: assert property (@(posedge clk_74a)
        (vs_seen && video_vs) |-> (cyc_since_vs == FRAME_CYCLES))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: video_vs period expected %0d got %0d",
                 $time, FRAME_CYCLES, $sampled(cyc_since_vs));
    end

    line_de_check: assert property (@(posedge clk_74a)
        video_hs |-> (de_in_line == 9'd0 || de_in_line == 9'd256))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: video_de cycles per line expected 256 got %0d",
                 $time, $sampled(de_in_line));
    end

    frame_lines_check: assert property (@(posedge clk_74a)
        (vs_seen && video_vs) |-> (lines_in_frame == 9'd224))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: active lines expected 224 got %0d",
                 $time, $sampled(lines_in_frame));
    end

    pixel_check: assert property (@(posedge clk_74a)
        (vs_seen && video_de) |-> (video_rgb == expected_pixel(de_in_line, lines_in_frame)))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: video_rgb at (%0d,%0d) expected %h got %h", $time,
                 $sampled(de_in_line), $sampled(lines_in_frame),
                 expected_pixel($sampled(de_in_line), $sampled(lines_in_frame)),
                 $sampled(video_rgb));
    end

    blank_check: assert property (@(posedge clk_74a) !video_de |-> (video_rgb == '0))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: video_rgb expected 000000 got %h",
                 $time, $sampled(video_rgb));
    end

    read_check: assert property (@(posedge clk_74a)
        bridge_rd |-> (bridge_rd_data == expected_read(bridge_addr)))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: bridge_rd_data at %h expected %h got %h", $time,
                 $sampled(bridge_addr), expected_read($sampled(bridge_addr)),
                 $sampled(bridge_rd_data));
    end

    settings_check: assert property (@(posedge clk_74a)
        run_live |-> (settings == shadow_settings))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: settings expected %h got %h",
                 $time, $sampled(shadow_settings), $sampled(settings));
    end

    menu_hold_check: assert property (@(posedge clk_74a)
        (run_live && menu_visible && $past(menu_visible)) |-> cpu_reset_n)
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: cpu_reset_n with the menu open expected 1 got 0", $time);
    end

    pulse_length_check: assert property (@(posedge clk_74a)
        (run_live && cpu_reset_n && low_run != 0) |-> (low_run == 2))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: cpu_reset_n low cycles expected 2 got %0d",
                 $time, $sampled(low_run));
    end

    pulse_source_check: assert property (@(posedge clk_74a)
        (run_live && $fell(cpu_reset_n)) |->
        (reset_armed && $past(menu_visible, 2) && !$past(menu_visible)))
    else begin
        fail_count++;
        $display("cpu_reset_n fell at %0t without a pending settings write and menu close",
                 $time);
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic write_bridge(input invaders_pkg::bridge_word_t addr,
                                input invaders_pkg::bridge_word_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr      = 1'b0;
    endtask

    task automatic read_bridge(input invaders_pkg::bridge_word_t addr);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(negedge clk_74a);
        bridge_rd   = 1'b0;
    endtask

    task automatic wait_frame_sync(input int limit);
        int n;
        n = 0;
        while (!video_vs && n < limit) begin
            @(negedge clk_74a);
            n++;
        end
        if (!video_vs) begin
            fail_count++;
            $display("timeout: no video_vs within %0d cycles", limit);
        end
        @(negedge clk_74a);
    endtask

    task automatic wait_core_reset(input logic level, input int limit);
        int n;
        n = 0;
        while (cpu_reset_n !== level && n < limit) begin
            @(negedge clk_74a);
            n++;
        end
        if (cpu_reset_n !== level) begin
            fail_count++;
            $display("timeout: cpu_reset_n did not reach %b within %0d cycles", level, limit);
        end
    endtask

    initial begin
        int i;
        int col;
        int offset;
        logic [31:0] word;
        logic [7:0] data;
        int test_lines [8];

        test_lines = '{0, 5, 60, 90, 130, 170, 200, 223};
        void'($urandom(RANDOM_SEED));
        for (i = 0; i < 8192; i++) begin
            shadow_vram[i] = '0;
        end
        clk_74a         = 1'b0;
        reset_n         = 1'b0;
        bridge_addr     = '0;
        bridge_wr       = 1'b0;
        bridge_rd       = 1'b0;
        bridge_wr_data  = '0;
        menu_visible    = 1'b0;
        shadow_settings = '0;
        reset_armed     = 1'b0;
        repeat (8) @(negedge clk_74a);
        reset_n = 1'b1;
        repeat (4) @(negedge clk_74a);

        // menu closes with nothing pending
        menu_visible = 1'b1;
        repeat (6) @(negedge clk_74a);
        menu_visible = 1'b0;
        repeat (12) @(negedge clk_74a);
        menu_visible = 1'b1;
        repeat (3) @(negedge clk_74a);

        // settings word, readback inside and outside the window
        for (i = 0; i < 4; i++) begin
            word = $urandom();
            write_bridge(32'h2000_0000, word);
            shadow_settings = word;
            reset_armed     = 1'b1;
            read_bridge(32'h2000_0000);
            read_bridge(32'h2000_000C);
            read_bridge(32'h2000_0010);
            read_bridge(32'h3000_0000 | ($urandom() & 32'h0FFF_FFFF));
            read_bridge(32'h1000_0000 | ($urandom() & 32'h0FFF_FFFF));
        end

        // pending reset held while the menu stays open
        repeat (40) @(negedge clk_74a);
        menu_visible = 1'b0;
        wait_core_reset(1'b0, 16);
        wait_core_reset(1'b1, 16);
        reset_armed = 1'b0;
        repeat (20) @(negedge clk_74a);
        menu_visible = 1'b1;
        repeat (6) @(negedge clk_74a);
        menu_visible = 1'b0;
        repeat (20) @(negedge clk_74a);

        // fill chosen lines during vertical blank
        wait_frame_sync(FRAME_CYCLES + 16);
        for (i = 0; i < 8; i++) begin
            for (col = 0; col < invaders_pkg::LINE_BYTES; col++) begin
                offset = (invaders_pkg::VRAM_LINE_BASE +
                          test_lines[i] * invaders_pkg::LINE_BYTES + col) % 8192;
                data   = 8'($urandom());
                word   = 32'h1000_0000 | ($urandom() & 32'h0FFF_E000) | 32'(offset);
                write_bridge(word, ($urandom() & 32'hFFFF_FF00) | 32'(data));
                shadow_vram[offset] = data;
            end
        end
        wait_frame_sync(FRAME_CYCLES + 16);
        wait_frame_sync(FRAME_CYCLES + 16);
        repeat (4) @(negedge clk_74a);

        $display("checks done: %0d mismatches, %0d other failures",
                 mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
